// File: include/fma_settings.svh
`ifndef FMA_SETTINGS_SVH
`define FMA_SETTINGS_SVH

// Half-precision format
`define FP_WIDTH   16
`define EXP_WIDTH  5
`define MAN_WIDTH  10
`define EXP_BIAS   15

// All-ones exponent of Inf
`define EXP_MAX    31

// 11 x 11 significand product with two integer bits
`define PROD_WIDTH 22

// Carry bit, product, three spare low bits
`define SUM_WIDTH  26

`endif

// File: source/fma_align_add.sv
`include "fma_settings.svh"

module fma_align_add import fma_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  product_t in,
	output sum_t     stage
);

	localparam int W     = `SUM_WIDTH;
	localparam int P_PAD = W - 1 - `PROD_WIDTH;   // Zeros below the product
	localparam int C_PAD = W - 3 - `MAN_WIDTH;    // Zeros below the addend

	logic              c_nonzero;
	logic [W-1:0]      mag_p;
	logic [W-1:0]      mag_c;
	logic signed [6:0] exp_p;
	logic signed [6:0] exp_c;
	logic              p_first;
	logic signed [6:0] diff;
	logic [5:0]        shamt;
	logic [W-1:0]      hi;
	logic [W-1:0]      lo_src;
	logic [W-1:0]      lo;
	logic [2*W-1:0]    shifted;
	logic              dropped;
	logic              hi_sign;
	logic              lo_sign;
	sum_t              nxt;

	// Both binary points at bit W-3
	assign c_nonzero = |in.c.exp;
	assign mag_p     = {1'b0, in.sig, {P_PAD{1'b0}}};
	assign mag_c     = {2'b00, c_nonzero, in.c.man, {C_PAD{1'b0}}};

	assign exp_p = in.exp;
	assign exp_c = $signed({2'b00, in.c.exp});

	assign p_first = exp_p >= exp_c;
	assign diff    = p_first ? exp_p - exp_c : exp_c - exp_p;
	assign shamt   = (diff > W) ? 6'(W) : diff[5:0];

	assign hi      = p_first ? mag_p : mag_c;
	assign lo_src  = p_first ? mag_c : mag_p;
	assign hi_sign = p_first ? in.sign : in.c.sign;
	assign lo_sign = p_first ? in.c.sign : in.sign;

	// Lower half catches what falls off the right
	assign shifted = {lo_src, {W{1'b0}}} >> shamt;
	assign lo      = shifted[2*W-1:W];
	assign dropped = |shifted[W-1:0];

	always_comb begin
		nxt.valid  = in.valid;
		nxt.sticky = 1'b0;
		if (in.prod_zero) begin
			// z follows c alone
			nxt.sign = in.c.sign;
			nxt.exp  = exp_c;
			nxt.mag  = mag_c;
		end else if (!c_nonzero) begin
			nxt.sign = in.sign;
			nxt.exp  = exp_p;
			nxt.mag  = mag_p;
		end else begin
			nxt.exp    = p_first ? exp_p : exp_c;
			nxt.sticky = dropped;
			if (in.sign == in.c.sign) begin
				nxt.sign = in.sign;
				nxt.mag  = hi + lo;
			end else if (hi >= lo) begin
				// Borrow for the lost bits keeps sticky as a positive remainder
				nxt.sign = hi_sign;
				nxt.mag  = hi - lo - dropped;
			end else begin
				nxt.sign = lo_sign;
				nxt.mag  = lo - hi;
			end
		end
	end

	always_ff @(posedge clk) begin
		stage <= nxt;
		if (rst) begin
			stage.valid <= 1'b0;
		end
	end

endmodule

// File: source/fma_multiply.sv
`include "fma_settings.svh"

module fma_multiply import fma_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  unpacked_t in,
	output product_t  stage
);

	localparam logic signed [6:0] BIAS = `EXP_BIAS;

	logic [`MAN_WIDTH:0] sig_a;
	logic [`MAN_WIDTH:0] sig_b;
	logic signed [6:0]   exp_a;
	logic signed [6:0]   exp_b;
	product_t            nxt;

	// Hidden bit always set as zero operands take the bypass later on
	assign sig_a = {1'b1, in.a.man};
	assign sig_b = {1'b1, in.b.man};

	assign exp_a = $signed({2'b00, in.a.exp});
	assign exp_b = $signed({2'b00, in.b.exp});

	always_comb begin
		nxt.valid     = in.valid;
		nxt.sign      = in.a.sign ^ in.b.sign;
		nxt.exp       = exp_a + exp_b - BIAS;   // One bias removed
		nxt.sig       = sig_a * sig_b;
		nxt.c         = in.c;
		nxt.prod_zero = in.prod_zero;
	end

	always_ff @(posedge clk) begin
		stage <= nxt;
		if (rst) begin
			stage.valid <= 1'b0;
		end
	end

endmodule

// File: source/fma_normalize_round.sv
`include "fma_settings.svh"

module fma_normalize_round import fma_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  sum_t  in,
	output fp16_t z,
	output logic  out_valid
);

	localparam int W        = `SUM_WIDTH;
	localparam int LZW      = $clog2(W + 1);
	localparam int FRAC_LSB = W - 1 - `MAN_WIDTH;

	// Leading one at bit W-1 while the point sits below bit W-3
	localparam logic signed [6:0] NORM_ADJ = 2;

	localparam logic [`FP_WIDTH-1:0] SAT_VALUE = {1'b0, {`EXP_WIDTH{1'b1}}, {`MAN_WIDTH{1'b0}}};

	logic [LZW-1:0]        lzc;
	logic [W-1:0]          norm;
	logic signed [6:0]     exp_in;
	logic signed [6:0]     exp_norm;
	logic signed [6:0]     exp_final;
	logic [`MAN_WIDTH-1:0] frac;
	logic                  guard;
	logic                  round_bit;
	logic                  sticky;
	logic                  round_up;
	logic [`MAN_WIDTH+1:0] rounded;
	logic [`MAN_WIDTH-1:0] frac_final;
	fp16_t                 result;

	function automatic logic [LZW-1:0] lead_zeros(input logic [W-1:0] v);
		logic [LZW-1:0] n;
		logic           found;
		n     = '0;
		found = 1'b0;
		for (int i = W - 1; i >= 0; i--) begin
			if (v[i]) begin
				found = 1'b1;
			end else if (!found) begin
				n = n + 1'b1;
			end
		end
		return n;
	endfunction

	assign exp_in   = in.exp;
	assign lzc      = lead_zeros(in.mag);
	assign norm     = in.mag << lzc;
	assign exp_norm = exp_in + NORM_ADJ - $signed(7'(lzc));

	// Fraction under the hidden one, then guard and round
	assign frac      = norm[W-2 -: `MAN_WIDTH];
	assign guard     = norm[FRAC_LSB-1];
	assign round_bit = norm[FRAC_LSB-2];
	assign sticky    = (|norm[FRAC_LSB-3:0]) | in.sticky;
	assign round_up  = guard & (round_bit | sticky | frac[0]);   // Ties to even
	assign rounded   = {2'b01, frac} + round_up;

	always_comb begin
		if (rounded[`MAN_WIDTH+1]) begin
			// Carry out of 1.111..1
			exp_final  = exp_norm + 7'sd1;
			frac_final = rounded[`MAN_WIDTH:1];
		end else begin
			exp_final  = exp_norm;
			frac_final = rounded[`MAN_WIDTH-1:0];
		end
	end

	// ReLU with underflow flushed to zero
	always_comb begin
		result = '0;
		if (!in.sign && (in.mag != '0) && (exp_final > 0)) begin
			if (exp_final >= `EXP_MAX) begin
				result = SAT_VALUE;
			end else begin
				result = '{sign: 1'b0, exp: exp_final[`EXP_WIDTH-1:0], man: frac_final};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in.valid;
		end
		if (in.valid) begin
			z <= result;   // Held until the next result
		end
	end

endmodule

// File: source/fma_pkg.sv
`include "fma_settings.svh"

package fma_pkg;

	typedef struct packed {
		logic                  sign;
		logic [`EXP_WIDTH-1:0] exp;
		logic [`MAN_WIDTH-1:0] man;
	} fp16_t;

	// Operands after the subnormal flush
	typedef struct packed {
		logic  valid;
		fp16_t a;
		fp16_t b;
		fp16_t c;
		logic  prod_zero;                 // a or b is zero
	} unpacked_t;

	typedef struct packed {
		logic                   valid;
		logic                   sign;
		logic signed [6:0]      exp;      // Biased and may leave 1..30
		logic [`PROD_WIDTH-1:0] sig;      // Two integer bits
		fp16_t                  c;
		logic                   prod_zero;
	} product_t;

	// Signed sum before normalization
	typedef struct packed {
		logic                  valid;
		logic                  sign;
		logic signed [6:0]     exp;
		logic [`SUM_WIDTH-1:0] mag;       // Point below bit SUM_WIDTH-3
		logic                  sticky;    // Lost bits under mag[0]
	} sum_t;

endpackage

// File: source/fma_top.sv
module fma_top import fma_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  in_valid,
	input  fp16_t a,
	input  fp16_t b,
	input  fp16_t c,
	output fp16_t z,
	output logic  out_valid
);

	unpacked_t unpacked;
	product_t  product;
	sum_t      sum;

	fma_unpack u_unpack (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.a        (a),
		.b        (b),
		.c        (c),
		.stage    (unpacked)
	);

	fma_multiply u_multiply (
		.clk   (clk),
		.rst   (rst),
		.in    (unpacked),
		.stage (product)
	);

	fma_align_add u_align_add (
		.clk   (clk),
		.rst   (rst),
		.in    (product),
		.stage (sum)
	);

	fma_normalize_round u_normalize_round (
		.clk       (clk),
		.rst       (rst),
		.in        (sum),
		.z         (z),
		.out_valid (out_valid)
	);

endmodule

// File: source/fma_unpack.sv
module fma_unpack import fma_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	input  fp16_t     a,
	input  fp16_t     b,
	input  fp16_t     c,
	output unpacked_t stage
);

	fp16_t     a_ftz;
	fp16_t     b_ftz;
	fp16_t     c_ftz;
	unpacked_t nxt;

	// Subnormal becomes zero of the same sign
	function automatic fp16_t flush(input fp16_t x);
		fp16_t y;
		y = x;
		if (x.exp == '0) begin
			y.man = '0;
		end
		return y;
	endfunction

	assign a_ftz = flush(a);
	assign b_ftz = flush(b);
	assign c_ftz = flush(c);

	always_comb begin
		nxt.valid     = in_valid;
		nxt.a         = a_ftz;
		nxt.b         = b_ftz;
		nxt.c         = c_ftz;
		nxt.prod_zero = (a_ftz.exp == '0) || (b_ftz.exp == '0);
	end

	always_ff @(posedge clk) begin
		stage <= nxt;
		if (rst) begin
			stage.valid <= 1'b0;
		end
	end

endmodule

// File: sources.f
+incdir+include
source/fma_pkg.sv
source/fma_unpack.sv
source/fma_multiply.sv
source/fma_align_add.sv
source/fma_normalize_round.sv
source/fma_top.sv
testbench/fma_sva.sv
testbench/fma_tb.sv

// File: testbench/fma_sva.sv
`include "fma_settings.svh"

module fma_sva import fma_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  in_valid,
	input fp16_t a,
	input fp16_t b,
	input fp16_t c,
	input fp16_t z,
	input logic  out_valid
);

	localparam int    DEPTH   = 4;
	localparam fp16_t ONE     = 16'h3C00;
	localparam fp16_t SAT     = 16'h7C00;
	localparam int    EXP_TOP = `EXP_MAX - 1;

	typedef struct packed {
		logic  valid;
		fp16_t a;
		fp16_t b;
		fp16_t c;
	} op_t;

	op_t        hist [DEPTH];
	op_t        old;
	logic [2:0] since_rst;
	logic       settled;
	logic       done;
	logic       bypass;
	logic       identity;
	logic       doubling;
	logic       cancel;
	logic       saturate;
	fp16_t      exp_bypass;
	fp16_t      exp_identity;
	fp16_t      exp_double;
	int         errors = 0;

	// Operands seen by the result now leaving the pipeline
	always_ff @(posedge clk) begin
		hist[0] <= '{valid: in_valid, a: a, b: b, c: c};
		for (int i = 1; i < DEPTH; i++) begin
			hist[i] <= hist[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			since_rst <= '0;
		end else if (since_rst != 3'(DEPTH)) begin
			since_rst <= since_rst + 1'b1;
		end
	end

	assign old     = hist[DEPTH-1];
	assign settled = since_rst == 3'(DEPTH);   // Pipeline refilled since reset
	assign done    = settled && out_valid;

	always_comb begin
		bypass   = (old.a.exp == '0) || (old.b.exp == '0);
		identity = !bypass && (old.b == ONE) && (old.c == '0);
		doubling = !bypass && (old.b == ONE) && (old.c == old.a) && (old.a.exp < 5'(EXP_TOP));
		cancel   = !bypass && (old.b == ONE) && (old.c == {~old.a.sign, old.a.exp, old.a.man});
		saturate = (old.a.exp == 5'(EXP_TOP)) && (old.b.exp == 5'(EXP_TOP)) &&
			!old.a.sign && !old.b.sign && (old.c == '0);
		exp_bypass   = (!old.c.sign && (old.c.exp != '0)) ? old.c : '0;
		exp_identity = old.a.sign ? '0 : old.a;
		exp_double     = old.a;
		exp_double.exp = old.a.exp + 1'b1;
		if (old.a.sign) begin
			exp_double = '0;   // ReLU
		end
	end

	a_reset_low: assert property (@(posedge clk) !settled |-> !out_valid)
		else begin
			$error("CHECK FAILED reset: expected out_valid 0 actual %0b", $sampled(out_valid));
			errors++;
		end

	a_latency: assert property (@(posedge clk) disable iff (rst)
		settled |-> out_valid == old.valid)
		else begin
			$error("CHECK FAILED latency: expected out_valid %0b actual %0b",
				$sampled(old.valid), $sampled(out_valid));
			errors++;
		end

	a_bypass: assert property (@(posedge clk) disable iff (rst)
		done && bypass |-> z == exp_bypass)
		else begin
			$error("CHECK FAILED product bypass: expected %h actual %h",
				$sampled(exp_bypass), $sampled(z));
			errors++;
		end

	a_identity: assert property (@(posedge clk) disable iff (rst)
		done && identity |-> z == exp_identity)
		else begin
			$error("CHECK FAILED identity: expected %h actual %h",
				$sampled(exp_identity), $sampled(z));
			errors++;
		end

	a_doubling: assert property (@(posedge clk) disable iff (rst)
		done && doubling |-> z == exp_double)
		else begin
			$error("CHECK FAILED exact doubling: expected %h actual %h",
				$sampled(exp_double), $sampled(z));
			errors++;
		end

	a_cancel: assert property (@(posedge clk) disable iff (rst)
		done && cancel |-> z == '0)
		else begin
			$error("CHECK FAILED cancellation: expected 0000 actual %h", $sampled(z));
			errors++;
		end

	a_saturate: assert property (@(posedge clk) disable iff (rst)
		done && saturate |-> z == SAT)
		else begin
			$error("CHECK FAILED saturation: expected %h actual %h", SAT, $sampled(z));
			errors++;
		end

endmodule

// File: testbench/fma_tb.sv
`include "fma_settings.svh"

module fma_tb import fma_pkg::*; ();

	localparam int    CLK_PERIOD   = 100;
	localparam int    RESET_CYCLES = 8;
	localparam int    IDLE_CYCLES  = 6;
	localparam int    FMA_LATENCY  = 4;
	localparam int    PHASE_OPS    = 16;
	localparam int    NUM_OPS      = PHASE_OPS * 6;
	localparam int    EXP_TOP      = `EXP_MAX - 1;
	localparam fp16_t ONE          = 16'h3C00;
	localparam fp16_t ZERO         = '0;
	localparam logic [15:0] SEED   = 16'd52;

	// Whole run in cycles with some margin
	localparam int WATCHDOG = (NUM_OPS + RESET_CYCLES + IDLE_CYCLES + FMA_LATENCY + 20) *
		CLK_PERIOD;

	logic        clk;
	logic        rst;
	logic        in_valid;
	fp16_t       a;
	fp16_t       b;
	fp16_t       c;
	fp16_t       z;
	logic        out_valid;
	logic [15:0] lfsr;
	int          strobes;
	int          results;

	fma_top i_fma_top (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.c         (c),
		.z         (z),
		.out_valid (out_valid)
	);

	bind fma_top fma_sva i_fma_sva (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.c         (c),
		.z         (z),
		.out_valid (out_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			results <= 0;
		end else if (out_valid) begin
			results <= results + 1;
		end
	end

	// Galois LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[14:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Normal operand with exponent in 1..exp_top
	task automatic random_operand(input int exp_top, output fp16_t x);
		logic [15:0] r;
		take_bits(1, r);
		x.sign = r[0];
		take_bits(5, r);
		x.exp = 5'((r % exp_top) + 1);
		take_bits(10, r);
		x.man = r[9:0];
	endtask

	task automatic send(input logic valid, input fp16_t op_a, input fp16_t op_b,
		input fp16_t op_c);
		@(posedge clk);
		in_valid <= valid;
		a        <= op_a;
		b        <= op_b;
		c        <= op_c;
		if (valid) begin
			strobes++;
		end
	endtask

	initial begin
		fp16_t       x;
		fp16_t       y;
		fp16_t       w;
		logic [15:0] r;
		clk      = 1'b0;
		rst      = 1'b1;
		in_valid = 1'b0;
		a        = ZERO;
		b        = ZERO;
		c        = ZERO;
		lfsr     = SEED;
		strobes  = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		repeat (IDLE_CYCLES) send(1'b0, ZERO, ZERO, ZERO);   // out_valid must stay low

		for (int i = 0; i < PHASE_OPS; i++) begin
			random_operand(EXP_TOP, x);
			random_operand(EXP_TOP, y);
			random_operand(EXP_TOP, w);
			take_bits(2, r);
			if (r[0]) begin
				x.exp = '0;
			end else begin
				y.exp = '0;
			end
			if (r[1]) begin
				w.exp = '0;   // Zero or subnormal addend
			end
			send(1'b1, x, y, w);
		end
		for (int i = 0; i < PHASE_OPS; i++) begin
			random_operand(EXP_TOP, x);
			send(1'b1, x, ONE, ZERO);
		end
		for (int i = 0; i < PHASE_OPS; i++) begin
			random_operand(EXP_TOP - 1, x);
			send(1'b1, x, ONE, x);
		end
		for (int i = 0; i < PHASE_OPS; i++) begin
			random_operand(EXP_TOP, x);
			w      = x;
			w.sign = ~x.sign;
			send(1'b1, x, ONE, w);
		end
		for (int i = 0; i < PHASE_OPS; i++) begin
			random_operand(EXP_TOP, x);
			random_operand(EXP_TOP, y);
			x.sign = 1'b0;
			y.sign = 1'b0;
			x.exp  = 5'(EXP_TOP);
			y.exp  = 5'(EXP_TOP);
			send(1'b1, x, y, ZERO);
		end

		// Strobes with gaps
		for (int i = 0; i < PHASE_OPS; i++) begin
			random_operand(EXP_TOP, x);
			random_operand(EXP_TOP, y);
			random_operand(EXP_TOP, w);
			take_bits(1, r);
			send(r[0], x, y, w);
		end
		send(1'b0, ZERO, ZERO, ZERO);

		while (results < strobes) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		if (i_fma_top.i_fma_sva.errors == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "Result checks reported errors");
		end
	end

	initial begin
		wait (i_fma_top.i_fma_sva.errors != 0);
		$display("TEST FAILED");
		$fatal(1, "A result check failed");
	end

	initial begin
		#(WATCHDOG);
		$display("TEST FAILED");
		$fatal(1, "The pipeline did not deliver all results within the time limit");
	end

endmodule
